//--- design/trace_pkg.sv
// Trace package: shared sizes, instruction word views and opcode class limit
package trace_pkg;

    //////////////////////////////
    // Pipeline and trace sizes
    //////////////////////////////
    localparam int SEQ_W   = 6;   // Sequence ID, wraps modulo 64
    localparam int STAGES  = 5;   // Fetch, decode, execute, memory, write-back
    localparam int STALL_W = 4;   // Per-instruction stall count, saturates at 15
    localparam int CYC_W   = 32;  // Free-running cycle counter

    // Datapath field widths
    localparam int PC_W    = 16;
    localparam int DATA_W  = 16;  // Execute result, memory address, WB data
    localparam int INSTR_W = 16;

    // Instruction word layout
    localparam int OP_W    = 4;
    localparam int REG_W   = 4;
    localparam int IMM_W   = 8;   // Also width of the rs,rt operand pair

    // Opcodes from here upward carry an immediate
    localparam logic [OP_W-1:0] IMM_OP_MIN = 4'd8;

    //////////////////////////////
    // Instruction word
    //////////////////////////////
    // Same 16 bits read two ways, selected by opcode class
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]  opcode;
            logic [REG_W-1:0] rd;
            logic [REG_W-1:0] rs;     // First source register
            logic [REG_W-1:0] rt;     // Second source register
        } r;                          // Register format
        struct packed {
            logic [OP_W-1:0]  opcode;
            logic [REG_W-1:0] rd;
            logic [IMM_W-1:0] imm;    // 8-bit immediate
        } i;                          // Immediate format
    } instr_u;

endpackage

//--- design/stage_tags_if.sv
// Stage tag bundle: per-stage sequence IDs, valids and live stall counts
`timescale 1ns/1ps

interface stage_tags_if;
    import trace_pkg::*;

    // Sequence ID of the instruction sitting in each stage
    logic [SEQ_W-1:0]   fetch_id;
    logic [SEQ_W-1:0]   decode_id;
    logic [SEQ_W-1:0]   ex_id;
    logic [SEQ_W-1:0]   mem_id;
    logic [SEQ_W-1:0]   wb_id;

    // Stage holds a real instruction, low for bubbles
    logic               fetch_valid;
    logic               decode_valid;
    logic               ex_valid;
    logic               mem_valid;
    logic               wb_valid;

    // Stall cycles gathered so far by the fetch and decode occupants
    logic [STALL_W-1:0] fetch_stalls;
    logic [STALL_W-1:0] decode_stalls;

    modport tracker (
        output fetch_id, decode_id, ex_id, mem_id, wb_id,
        output fetch_valid, decode_valid, ex_valid, mem_valid, wb_valid,
        output fetch_stalls, decode_stalls
    );

    modport store (
        input fetch_id, decode_id, ex_id, mem_id, wb_id,
        input fetch_valid, decode_valid, ex_valid, mem_valid, wb_valid,
        input decode_stalls
    );

    modport reporter (input wb_id, wb_valid);  // Only the retiring stage matters

endinterface

//--- design/stage_id_tracker.sv
// Stage ID tracker: sequence IDs and valids down the pipe, stall counting, halt drain
`timescale 1ns/1ps

module stage_id_tracker (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          stall,      // Level, holds fetch and decode
    input  logic          hlt,        // Level, stops issue once sampled
    stage_tags_if.tracker tags,
    output logic          drained     // Halt seen and pipe empty
);
    import trace_pkg::*;

    logic [SEQ_W-1:0]  next_id;       // ID given to the next fetched instruction
    logic              halt_seen;
    logic              cap_stall;     // Previous cycle was stalled
    logic              issue;
    logic [STAGES-1:0] valid_vec;

    // New instruction enters fetch only on a free, unhalted cycle
    assign issue     = !stall && !halt_seen && !hlt;
    assign valid_vec = {tags.fetch_valid, tags.decode_valid, tags.ex_valid,
                        tags.mem_valid, tags.wb_valid};

    // Saturating add for the stall counters
    function automatic logic [STALL_W-1:0] sat_inc(input logic [STALL_W-1:0] v);
        return (v == {STALL_W{1'b1}}) ? v : v + 1'b1;
    endfunction

    ////////////////////////////////
    // ID shift chain
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_id        <= '0;
            tags.fetch_id  <= '0;
            tags.decode_id <= '0;
            tags.ex_id     <= '0;
            tags.mem_id    <= '0;
            tags.wb_id     <= '0;
        end else begin
            tags.ex_id  <= tags.decode_id;  // Back half always moves
            tags.mem_id <= tags.ex_id;
            tags.wb_id  <= tags.mem_id;
            if (!stall) begin
                tags.fetch_id  <= next_id;
                tags.decode_id <= tags.fetch_id;
                if (issue)
                    next_id <= next_id + 1'b1;  // Wraps at 64
            end
        end
    end

    // Valid chain, execute takes a bubble while front half is held
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tags.fetch_valid  <= 1'b0;
            tags.decode_valid <= 1'b0;
            tags.ex_valid     <= 1'b0;
            tags.mem_valid    <= 1'b0;
            tags.wb_valid     <= 1'b0;
        end else begin
            tags.mem_valid <= tags.ex_valid;
            tags.wb_valid  <= tags.mem_valid;
            if (stall) begin
                tags.ex_valid <= 1'b0;           // Bubble
            end else begin
                tags.fetch_valid  <= issue;
                tags.decode_valid <= tags.fetch_valid;
                tags.ex_valid     <= tags.decode_valid;
            end
        end
    end

    ////////////////////////////////
    // Stall counts
    ////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tags.fetch_stalls  <= '0;
            tags.decode_stalls <= '0;
        end else if (stall) begin
            if (tags.fetch_valid)
                tags.fetch_stalls <= sat_inc(tags.fetch_stalls);
            if (tags.decode_valid)
                tags.decode_stalls <= sat_inc(tags.decode_stalls);
        end else begin
            tags.fetch_stalls  <= '0;                  // New fetch starts clean
            tags.decode_stalls <= tags.fetch_stalls;   // Count follows instruction
        end
    end

    // Halt latch, stall flag and drain detect
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halt_seen <= 1'b0;
            cap_stall <= 1'b0;
            drained   <= 1'b0;
        end else begin
            cap_stall <= stall;
            if (hlt)
                halt_seen <= 1'b1;                     // Sticky until reset
            if (halt_seen && !(|valid_vec))
                drained <= 1'b1;
        end
    end

    // A stalled edge must leave a bubble in execute
    a_bubble_after_stall : assert property (@(posedge clk) disable iff (!rst_n)
        cap_stall |-> !tags.ex_valid);

endmodule

//--- design/trace_store.sv
// Trace store: per-instruction record memory filled stage by stage, read at write-back
`timescale 1ns/1ps

module trace_store (
    input  logic                             clk,
    input  logic                             rst_n,
    stage_tags_if.store                      tags,
    input  logic [trace_pkg::PC_W-1:0]       fetch_pc,
    input  logic [trace_pkg::INSTR_W-1:0]    decode_instr,
    input  logic [trace_pkg::DATA_W-1:0]     ex_result,
    input  logic [trace_pkg::DATA_W-1:0]     mem_addr,
    input  logic [trace_pkg::DATA_W-1:0]     wb_data,
    output logic [trace_pkg::PC_W-1:0]       rd_pc,
    output trace_pkg::instr_u                rd_instr,
    output logic [trace_pkg::DATA_W-1:0]     rd_result,
    output logic [trace_pkg::DATA_W-1:0]     rd_addr,
    output logic [trace_pkg::DATA_W-1:0]     rd_wdata,
    output logic [trace_pkg::STALL_W-1:0]    rd_stalls
);
    import trace_pkg::*;

    localparam int DEPTH = 1 << SEQ_W;  // One slot per sequence ID

    ////////////////////////////////
    // Record fields
    ////////////////////////////////
    logic [PC_W-1:0]    pc_mem     [DEPTH];
    logic [INSTR_W-1:0] instr_mem  [DEPTH];
    logic [DATA_W-1:0]  result_mem [DEPTH];
    logic [DATA_W-1:0]  addr_mem   [DEPTH];
    logic [STALL_W-1:0] stalls_mem [DEPTH];

    // Each stage writes its own field at its occupant's slot
    always_ff @(posedge clk) begin
        if (tags.fetch_valid)
            pc_mem[tags.fetch_id] <= fetch_pc;
        if (tags.decode_valid) begin
            // Held decode keeps rewriting, so the last value and final count win
            instr_mem[tags.decode_id]  <= decode_instr;
            stalls_mem[tags.decode_id] <= tags.decode_stalls;
        end
        if (tags.ex_valid)
            result_mem[tags.ex_id] <= ex_result;
        if (tags.mem_valid)
            addr_mem[tags.mem_id] <= mem_addr;
    end

    ////////////////////////////////
    // Read port at write-back
    ////////////////////////////////
    assign rd_pc     = pc_mem[tags.wb_id];
    assign rd_instr  = instr_mem[tags.wb_id];
    assign rd_result = result_mem[tags.wb_id];
    assign rd_addr   = addr_mem[tags.wb_id];
    assign rd_stalls = stalls_mem[tags.wb_id];

    // WB data shows up in the very cycle the record is read, so it goes straight out
    assign rd_wdata  = wb_data;

    // A slot being refilled by fetch must not be the one retiring
    a_no_id_alias : assert property (@(posedge clk) disable iff (!rst_n)
        (tags.fetch_valid && tags.wb_valid) |-> (tags.fetch_id != tags.wb_id));

endmodule

//--- design/retire_reporter.sv
// Retire reporter: registers one decoded retire record per write-back, plus cycle count
`timescale 1ns/1ps

module retire_reporter (
    input  logic                          clk,
    input  logic                          rst_n,
    stage_tags_if.reporter                tags,
    input  logic [trace_pkg::PC_W-1:0]    rd_pc,
    input  trace_pkg::instr_u             rd_instr,
    input  logic [trace_pkg::DATA_W-1:0]  rd_result,
    input  logic [trace_pkg::DATA_W-1:0]  rd_addr,
    input  logic [trace_pkg::DATA_W-1:0]  rd_wdata,
    input  logic [trace_pkg::STALL_W-1:0] rd_stalls,
    output logic                          retire_valid,    // One-cycle pulse
    output logic [trace_pkg::SEQ_W-1:0]   retire_seq,
    output logic [trace_pkg::PC_W-1:0]    retire_pc,
    output logic [trace_pkg::REG_W-1:0]   retire_rd,
    output logic [trace_pkg::IMM_W-1:0]   retire_operand,  // {rs,rt} or imm
    output logic [trace_pkg::DATA_W-1:0]  retire_result,
    output logic [trace_pkg::DATA_W-1:0]  retire_addr,
    output logic [trace_pkg::DATA_W-1:0]  retire_wdata,
    output logic [trace_pkg::STALL_W-1:0] retire_stalls,
    output logic [trace_pkg::CYC_W-1:0]   retire_cycle     // Cycle of the WB stage
);
    import trace_pkg::*;

    logic [CYC_W-1:0] cycle_cnt;
    logic [SEQ_W-1:0] exp_seq;      // Sequence expected on the next pulse
    logic             is_imm;
    logic [REG_W-1:0] dec_rd;
    logic [IMM_W-1:0] dec_operand;

    ////////////////////////////////
    // Instruction decode
    ////////////////////////////////
    assign is_imm      = (rd_instr.r.opcode >= IMM_OP_MIN);
    assign dec_rd      = is_imm ? rd_instr.i.rd : rd_instr.r.rd;
    assign dec_operand = is_imm ? rd_instr.i.imm : {rd_instr.r.rs, rd_instr.r.rt};

    // Free-running, reads 0 on the first cycle out of reset
    always_ff @(posedge clk) begin
        if (!rst_n)
            cycle_cnt <= '0;
        else
            cycle_cnt <= cycle_cnt + 1'b1;
    end

    // Pulse and sequence tracking
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retire_valid <= 1'b0;
            exp_seq      <= '0;
        end else begin
            retire_valid <= tags.wb_valid;
            if (retire_valid)
                exp_seq <= retire_seq + 1'b1;
        end
    end

    // Record payload, loaded only while WB holds an instruction
    always_ff @(posedge clk) begin
        if (tags.wb_valid) begin
            retire_seq     <= tags.wb_id;
            retire_pc      <= rd_pc;
            retire_rd      <= dec_rd;
            retire_operand <= dec_operand;
            retire_result  <= rd_result;
            retire_addr    <= rd_addr;
            retire_wdata   <= rd_wdata;
            retire_stalls  <= rd_stalls;
            retire_cycle   <= cycle_cnt;
        end
    end

    // Records leave in order, no gaps, restarting at 0 after reset
    a_seq_in_order : assert property (@(posedge clk) disable iff (!rst_n)
        retire_valid |-> (retire_seq == exp_seq));

endmodule

//--- design/pipe_trace_top.sv
// Pipeline trace top: ID tracker, record store and retire reporter behind plain ports
`timescale 1ns/1ps

module pipe_trace_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          hlt,
    input  logic [trace_pkg::PC_W-1:0]    fetch_pc,
    input  logic [trace_pkg::INSTR_W-1:0] decode_instr,
    input  logic [trace_pkg::DATA_W-1:0]  ex_result,
    input  logic [trace_pkg::DATA_W-1:0]  mem_addr,
    input  logic [trace_pkg::DATA_W-1:0]  wb_data,
    output logic                          retire_valid,
    output logic [trace_pkg::SEQ_W-1:0]   retire_seq,
    output logic [trace_pkg::PC_W-1:0]    retire_pc,
    output logic [trace_pkg::REG_W-1:0]   retire_rd,
    output logic [trace_pkg::IMM_W-1:0]   retire_operand,
    output logic [trace_pkg::DATA_W-1:0]  retire_result,
    output logic [trace_pkg::DATA_W-1:0]  retire_addr,
    output logic [trace_pkg::DATA_W-1:0]  retire_wdata,
    output logic [trace_pkg::STALL_W-1:0] retire_stalls,
    output logic [trace_pkg::CYC_W-1:0]   retire_cycle,
    output logic                          halted
);
    import trace_pkg::*;

    stage_tags_if tags ();

    // Store to reporter read path
    logic [PC_W-1:0]    rd_pc;
    instr_u             rd_instr;
    logic [DATA_W-1:0]  rd_result;
    logic [DATA_W-1:0]  rd_addr;
    logic [DATA_W-1:0]  rd_wdata;
    logic [STALL_W-1:0] rd_stalls;

    stage_id_tracker u_tracker (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .hlt     (hlt),
        .tags    (tags.tracker),
        .drained (halted)          // Pipe empty after halt
    );

    trace_store u_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .tags         (tags.store),
        .fetch_pc     (fetch_pc),
        .decode_instr (decode_instr),
        .ex_result    (ex_result),
        .mem_addr     (mem_addr),
        .wb_data      (wb_data),
        .rd_pc        (rd_pc),
        .rd_instr     (rd_instr),
        .rd_result    (rd_result),
        .rd_addr      (rd_addr),
        .rd_wdata     (rd_wdata),
        .rd_stalls    (rd_stalls)
    );

    retire_reporter u_reporter (
        .clk            (clk),
        .rst_n          (rst_n),
        .tags           (tags.reporter),
        .rd_pc          (rd_pc),
        .rd_instr       (rd_instr),
        .rd_result      (rd_result),
        .rd_addr        (rd_addr),
        .rd_wdata       (rd_wdata),
        .rd_stalls      (rd_stalls),
        .retire_valid   (retire_valid),
        .retire_seq     (retire_seq),
        .retire_pc      (retire_pc),
        .retire_rd      (retire_rd),
        .retire_operand (retire_operand),
        .retire_result  (retire_result),
        .retire_addr    (retire_addr),
        .retire_wdata   (retire_wdata),
        .retire_stalls  (retire_stalls),
        .retire_cycle   (retire_cycle)
    );

endmodule

//--- tb/tb_pipe_trace.sv
// Pipeline trace testbench with a shadow pipe model, random stalls and halts and retire checks
`timescale 1ns/1ps

module tb_pipe_trace;
    import trace_pkg::*;

    localparam int N_INSTR = 200;            // Instructions issued over all phases
    localparam int TIMEOUT = N_INSTR * 20;   // Cycle limit for the whole run

    // Predicted retire record with every field widened to 32 bits
    typedef struct packed {
        logic [31:0] seq;
        logic [31:0] pc;
        logic [31:0] rd;
        logic [31:0] operand;
        logic [31:0] result;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] stalls;
        logic [31:0] cycle;
    } rec_t;

    logic                clk;
    logic                rst_n;
    logic                stall;
    logic                hlt;
    logic [PC_W-1:0]     fetch_pc;
    logic [INSTR_W-1:0]  decode_instr;
    logic [DATA_W-1:0]   ex_result;
    logic [DATA_W-1:0]   mem_addr;
    logic [DATA_W-1:0]   wb_data;
    logic                retire_valid;
    logic [SEQ_W-1:0]    retire_seq;
    logic [PC_W-1:0]     retire_pc;
    logic [REG_W-1:0]    retire_rd;
    logic [IMM_W-1:0]    retire_operand;
    logic [DATA_W-1:0]   retire_result;
    logic [DATA_W-1:0]   retire_addr;
    logic [DATA_W-1:0]   retire_wdata;
    logic [STALL_W-1:0]  retire_stalls;
    logic [CYC_W-1:0]    retire_cycle;
    logic                halted;

    //////////////////////////////
    // Shadow pipeline state
    //////////////////////////////
    logic [31:0] lcg_state = 32'h300f;
    int          cyc;                         // Cycle number since reset release
    int          ticks;
    int          issued;                      // Global instruction index
    int          run_count;                   // Instructions since last reset
    int          last_idx;                    // Final instruction before halt
    int          halt_cyc;
    int          wr_ptr;
    int          rd_ptr;
    int          r_seen;
    int          i_seen;
    bit          hseen;
    bit          halt_due;
    int          occ [STAGES];                // Index per stage or -1 for a bubble
    logic [15:0] field_log [N_INSTR][STAGES]; // pc, instr, result, addr, wdata
    int          seq_log [N_INSTR];
    int          raw_stalls [N_INSTR];        // Unsaturated stall cycles
    int          fetch_cyc [N_INSTR];
    int          wb_cyc [N_INSTR];
    int          exp_list [N_INSTR];          // Retire order

    pipe_trace_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                // 4 ns period
    end

    always @(posedge clk) begin
        cyc <= rst_n ? cyc + 1 : 0;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (exp === got)
            else abort_run($sformatf("MISMATCH %s exp=%h got=%h", name, exp, got));
    endtask

    // Expected record from the logged stage values and the stall history
    function automatic rec_t expect_record(input int idx);
        rec_t        r;
        logic [15:0] iw;
        int          s;
        iw = field_log[idx][1];
        s = (raw_stalls[idx] > 15) ? 15 : raw_stalls[idx];   // Counter saturates
        r.seq = 32'(seq_log[idx]);
        r.pc = 32'(field_log[idx][0]);
        r.rd = 32'(iw[11:8]);                 // Same place in both formats
        r.operand = 32'(iw[7:0]);             // Low byte holds imm or the rs and rt pair
        r.result = 32'(field_log[idx][2]);
        r.addr = 32'(field_log[idx][3]);
        r.wdata = 32'(field_log[idx][4]);
        r.stalls = 32'(s);
        r.cycle = 32'(fetch_cyc[idx] + 4 + raw_stalls[idx]);
        return r;
    endfunction

    //////////////////////////////
    // Stimulus for one cycle per call
    //////////////////////////////
    task automatic drive_cycle(input bit rand_stall, input bit want_hlt);
        logic [31:0] r;
        logic [15:0] val;
        bit          issue;
        int          k;
        r = lcg_next();
        stall = rand_stall && (r[17:16] == 2'b00);   // About one cycle in four
        hlt = want_hlt;
        for (k = 0; k < STAGES; k++) begin
            r = lcg_next();
            val = r[31:16];
            case (k)
                0: fetch_pc = val;
                1: decode_instr = val;
                2: ex_result = val;
                3: mem_addr = val;
                default: wb_data = val;
            endcase
            if (occ[k] >= 0)
                field_log[occ[k]][k] = val;   // Held stage overwrites so the last value wins
        end
        if (stall) begin
            for (k = 0; k < 2; k++)
                if (occ[k] >= 0)
                    raw_stalls[occ[k]]++;
        end
        if (occ[4] >= 0) begin                // Pulse due next cycle
            wb_cyc[occ[4]] = cyc;
            exp_list[wr_ptr] = occ[4];
            wr_ptr++;
            if (hseen && occ[4] == last_idx) begin
                halt_cyc = cyc + 2;
                halt_due = 1'b1;
            end
        end
        issue = !stall && !want_hlt && !hseen;
        if (want_hlt) begin
            hseen = 1'b1;
            last_idx = issued - 1;
        end
        occ[4] = occ[3];                      // Back half always moves
        occ[3] = occ[2];
        if (stall) begin
            occ[2] = -1;                      // Bubble into execute
        end else begin
            occ[2] = occ[1];
            occ[1] = occ[0];
            occ[0] = issue ? issued : -1;
        end
        if (issue) begin
            seq_log[issued] = run_count % 64;
            fetch_cyc[issued] = cyc + 1;
            raw_stalls[issued] = 0;
            issued++;
            run_count++;
        end
        @(negedge clk);
    endtask

    task automatic apply_reset();
        int k;
        rst_n = 1'b0;
        stall = 1'b0;
        hlt = 1'b0;
        fetch_pc = '0;
        decode_instr = '0;
        ex_result = '0;
        mem_addr = '0;
        wb_data = '0;
        for (k = 0; k < STAGES; k++)
            occ[k] = -1;
        hseen = 1'b0;
        halt_due = 1'b0;
        run_count = 0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        assert (!retire_valid && !halted)
            else abort_run("retire_valid or halted is still high after reset");
    endtask

    // Issue a batch, optionally halt and let the pipe drain
    task automatic issue_batch(input int count, input bit rand_stall, input bit end_halt);
        int target;
        target = issued + count;
        while (issued < target)
            drive_cycle(rand_stall, 1'b0);
        if (end_halt) begin
            drive_cycle(rand_stall, 1'b1);
            while (!halted)
                drive_cycle(rand_stall, 1'b0);
            repeat (6) drive_cycle(rand_stall, 1'b0);   // Nothing more may retire
        end
    endtask

    //////////////////////////////
    // Retire checker
    //////////////////////////////
    initial begin
        rec_t e;
        int   idx;
        bit   exp_halt;
        forever begin
            @(posedge clk);                   // Registered outputs still hold this cycle
            if (!rst_n) begin
                rd_ptr = wr_ptr;              // In-flight records are dropped
            end else begin
                if (retire_valid) begin
                    assert (rd_ptr < wr_ptr)
                        else abort_run("Retire pulse with no instruction due to retire");
                    idx = exp_list[rd_ptr];
                    rd_ptr++;
                    assert (wb_cyc[idx] + 1 == cyc)
                        else abort_run("Retire pulse arrived in the wrong cycle");
                    e = expect_record(idx);
                    check_equal("retire_seq", e.seq, 32'(retire_seq));
                    check_equal("retire_pc", e.pc, 32'(retire_pc));
                    check_equal("retire_rd", e.rd, 32'(retire_rd));
                    check_equal("retire_operand", e.operand, 32'(retire_operand));
                    check_equal("retire_result", e.result, 32'(retire_result));
                    check_equal("retire_addr", e.addr, 32'(retire_addr));
                    check_equal("retire_wdata", e.wdata, 32'(retire_wdata));
                    check_equal("retire_stalls", e.stalls, 32'(retire_stalls));
                    check_equal("retire_cycle", e.cycle, 32'(retire_cycle));
                    if (field_log[idx][1][15:12] >= IMM_OP_MIN)
                        i_seen++;
                    else
                        r_seen++;
                end else begin
                    assert (rd_ptr == wr_ptr || wb_cyc[exp_list[rd_ptr]] + 1 > cyc)
                        else abort_run("An expected retire pulse did not arrive");
                end
                exp_halt = halt_due && (cyc >= halt_cyc);
                check_equal("halted", 32'(exp_halt), 32'(halted));
            end
        end
    end

    initial begin
        while (ticks < TIMEOUT) begin
            @(posedge clk);
            ticks++;
        end
        abort_run($sformatf("Timeout, run still going after %0d cycles", ticks));
    end

    initial begin
        apply_reset();
        issue_batch(70, 1'b0, 1'b1);          // No stalls, seq wraps, halt and drain
        apply_reset();
        issue_batch(60, 1'b1, 1'b0);          // Random stalls cut short by a reset in flight
        apply_reset();
        issue_batch(70, 1'b1, 1'b1);          // Fresh run from seq 0 that halts at the end
        assert (rd_ptr == wr_ptr)
            else abort_run("Run ended with retire records still outstanding");
        assert (r_seen > 0 && i_seen > 0)
            else abort_run("Only one instruction format was retired");
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- files.f
design/trace_pkg.sv
design/stage_tags_if.sv
design/stage_id_tracker.sv
design/trace_store.sv
design/retire_reporter.sv
design/pipe_trace_top.sv
tb/tb_pipe_trace.sv

//--- Makefile
# Verilator build and run for the pipeline trace testbench

VERILATOR ?= verilator
TOP       ?= tb_pipe_trace
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
